// File: rtl/mm_defs.svh
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

`define MM_DATA_W       64
`define MM_ADDR_W       32
`define MM_PAGE_BITS    12
`define MM_TLB_ENTRIES  4
`define MM_CACHE_LINES  8
`define MM_OP_W         4

// Bit 3 store, bit 2 unsigned, bits 1:0 log2 of size in bytes
`define MM_OP_LB   4'b0000
`define MM_OP_LH   4'b0001
`define MM_OP_LW   4'b0010
`define MM_OP_LD   4'b0011
`define MM_OP_LBU  4'b0100
`define MM_OP_LHU  4'b0101
`define MM_OP_LWU  4'b0110
`define MM_OP_SB   4'b1000
`define MM_OP_SH   4'b1001
`define MM_OP_SW   4'b1010
`define MM_OP_SD   4'b1011

`endif

// File: rtl/mm_pkg.sv
`default_nettype none

`include "mm_defs.svh"

package mm_pkg;

  // Same address seen as page number/offset or doubleword/lane
  typedef union packed {
    struct packed {
      logic [`MM_ADDR_W-`MM_PAGE_BITS-1:0] vpn;
      logic [`MM_PAGE_BITS-1:0]            offset;
    } page;
    struct packed {
      logic [`MM_ADDR_W-4:0] addr;
      logic [2:0]            lane;
    } word;
  } mm_vaddr_u;

endpackage

`default_nettype wire

// File: rtl/mm_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

interface mem_bus_if;
  logic                  req;
  logic                  we;
  logic [`MM_ADDR_W-1:0] addr;
  logic [`MM_DATA_W-1:0] wdata;
  logic                  ack;
  logic [`MM_DATA_W-1:0] rdata;

  modport requester (output req, we, addr, wdata, input ack, rdata);
  modport arbiter   (input req, we, addr, wdata, output ack, rdata);
endinterface

interface xlate_if;
  logic                  req;
  mm_pkg::mm_vaddr_u     vaddr;
  logic                  done;
  logic [`MM_ADDR_W-1:0] paddr;  // Held until the next done

  modport master (output req, vaddr, input done, paddr);
  modport slave  (input req, vaddr, output done, paddr);
endinterface

interface cache_if;
  logic                  req;
  logic                  we;
  logic [`MM_ADDR_W-1:0] addr;
  logic [`MM_DATA_W-1:0] wdata;
  logic                  done;
  logic [`MM_DATA_W-1:0] rdata;

  modport master (output req, we, addr, wdata, input done, rdata);
  modport slave  (input req, we, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

// File: rtl/mm_lane_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_lane_unit (
  input  logic [`MM_OP_W-1:0]   op,
  input  logic [2:0]            lane,
  input  logic [`MM_DATA_W-1:0] word,
  input  logic [`MM_DATA_W-1:0] store_data,
  output logic [`MM_DATA_W-1:0] load_value,
  output logic [`MM_DATA_W-1:0] merged_word
);

  logic [5:0]            shamt;
  logic [`MM_DATA_W-1:0] shifted;
  logic [`MM_DATA_W-1:0] size_mask;
  logic [`MM_DATA_W-1:0] lane_mask;
  logic                  sx;

  assign shamt   = {lane, 3'b000};  // Byte lane to bit offset
  assign shifted = word >> shamt;

  // 8 << size bits of ones; a doubleword shifts everything out
  assign size_mask = ~({`MM_DATA_W{1'b1}} << (7'd8 << op[1:0]));
  assign lane_mask = size_mask << shamt;

  assign merged_word = (word & ~lane_mask) | ((store_data << shamt) & lane_mask);

  always_comb begin
    case (op[1:0])
      2'd0: sx = shifted[7];
      2'd1: sx = shifted[15];
      2'd2: sx = shifted[31];
      default: sx = shifted[`MM_DATA_W-1];
    endcase
    sx = sx & ~op[2];  // Unsigned loads zero-extend
  end

  always_comb begin
    case (op[1:0])
      2'd0: load_value = {{(`MM_DATA_W-8){sx}}, shifted[7:0]};
      2'd1: load_value = {{(`MM_DATA_W-16){sx}}, shifted[15:0]};
      2'd2: load_value = {{(`MM_DATA_W-32){sx}}, shifted[31:0]};
      default: load_value = shifted;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/mm_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_access_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [`MM_OP_W-1:0]   op,
  input  logic [`MM_ADDR_W-1:0] vaddr,
  input  logic [`MM_DATA_W-1:0] store_data,
  input  logic                  flush,
  output logic                  busy,
  output logic                  done,
  output logic [`MM_DATA_W-1:0] load_data,
  output logic [`MM_ADDR_W-1:0] paddr,
  xlate_if.master               xlate,
  cache_if.master               cache
);

  localparam logic [1:0] S_IDLE  = 2'd0,
                         S_XLATE = 2'd1,
                         S_READ  = 2'd2,
                         S_WRITE = 2'd3;

  logic [1:0]            state;
  logic [`MM_OP_W-1:0]   op_r;
  logic [2:0]            lane_r;
  logic [`MM_DATA_W-1:0] sdata_r;
  logic [`MM_DATA_W-1:0] load_value;
  logic [`MM_DATA_W-1:0] merged_word;
  mm_pkg::mm_vaddr_u     va_in;
  mm_pkg::mm_vaddr_u     va_dw;
  logic                  is_store;
  logic                  is_dword;
  logic                  rd_issue;
  logic                  wr_issue;
  logic                  finish;

  assign va_in = vaddr;

  always_comb begin
    va_dw = va_in;
    va_dw.word.lane = '0;  // Translate the doubleword address
  end

  assign is_store = op_r[3];
  assign is_dword = (op_r[1:0] == 2'b11);
  assign busy     = (state != S_IDLE);

  assign rd_issue = (state == S_XLATE) && xlate.done && !(is_store && is_dword);
  assign wr_issue = ((state == S_XLATE) && xlate.done && is_store && is_dword) ||
                    ((state == S_READ) && cache.done && is_store);
  assign finish   = cache.done && !flush &&
                    (((state == S_READ) && !is_store) || (state == S_WRITE));

  assign xlate.req   = (state == S_IDLE) && start && !flush;
  assign xlate.vaddr = va_dw;
  assign cache.req   = (rd_issue || wr_issue) && !flush;
  assign cache.we    = wr_issue;
  assign cache.addr  = xlate.paddr;  // TLB holds it for the whole operation
  assign cache.wdata = (state == S_READ) ? merged_word : sdata_r;

  mm_lane_unit i_lane (
    .op          (op_r),
    .lane        (lane_r),
    .word        (cache.rdata),
    .store_data  (sdata_r),
    .load_value  (load_value),
    .merged_word (merged_word)
  );

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      state <= S_IDLE;
      done  <= 1'b0;
    end else begin
      done <= finish;
      case (state)
        S_IDLE:  if (start) state <= S_XLATE;
        S_XLATE: if (xlate.done) state <= (is_store && is_dword) ? S_WRITE : S_READ;
        S_READ:  if (cache.done) state <= is_store ? S_WRITE : S_IDLE;
        default: if (cache.done) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && start) begin
      op_r    <= op;
      lane_r  <= va_in.word.lane;
      sdata_r <= store_data;
    end
    if (finish) begin
      load_data <= is_store ? '0 : load_value;
      paddr     <= {xlate.paddr[`MM_ADDR_W-1:3], lane_r};
    end
  end

endmodule

`default_nettype wire

// File: rtl/mm_tlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_tlb (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic [`MM_ADDR_W-1:0] ptbr,
  xlate_if.slave                xlate,
  mem_bus_if.requester          bus
);

  localparam int ADDR_W = `MM_ADDR_W;
  localparam int VPN_W  = `MM_ADDR_W - `MM_PAGE_BITS;
  localparam int IDX_W  = $clog2(`MM_TLB_ENTRIES);
  localparam int TAG_W  = VPN_W - IDX_W;

  localparam logic [1:0] T_IDLE  = 2'd0,
                         T_WALK  = 2'd1,
                         T_RETRY = 2'd2;

  logic [1:0]                 state;
  logic [`MM_TLB_ENTRIES-1:0] valid;
  logic [TAG_W-1:0]           tag_mem [`MM_TLB_ENTRIES];
  logic [VPN_W-1:0]           ppn_mem [`MM_TLB_ENTRIES];
  logic [VPN_W-1:0]           vpn_r;
  logic [`MM_PAGE_BITS-1:0]   off_r;
  logic [VPN_W-1:0]           walk_vpn;
  logic [IDX_W-1:0]           idx;
  logic [IDX_W-1:0]           fill_idx;
  logic                       hit;
  logic                       discard;  // Walk still on the bus after a flush
  logic                       pend;     // New lookup waiting behind a discarded walk

  assign idx      = xlate.vaddr.page.vpn[IDX_W-1:0];
  assign fill_idx = vpn_r[IDX_W-1:0];
  assign hit      = valid[idx] && (tag_mem[idx] == xlate.vaddr.page.vpn[VPN_W-1:IDX_W]);
  assign walk_vpn = (state == T_IDLE) ? xlate.vaddr.page.vpn : vpn_r;

  assign bus.we    = 1'b0;
  assign bus.wdata = '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= T_IDLE;
      valid      <= '0;
      xlate.done <= 1'b0;
      bus.req    <= 1'b0;
      discard    <= 1'b0;
      pend       <= 1'b0;
    end else begin
      xlate.done <= 1'b0;
      case (state)
        T_IDLE: begin
          if (xlate.req && hit) begin
            xlate.done <= 1'b1;
          end else if (xlate.req) begin
            bus.req <= 1'b1;
            state   <= T_WALK;
          end
        end
        T_WALK: begin
          if (xlate.req) pend <= 1'b1;
          if (bus.ack) begin
            bus.req <= 1'b0;
            discard <= 1'b0;
            if (!discard && !flush) begin
              valid[fill_idx] <= 1'b1;
              xlate.done      <= 1'b1;
              state           <= T_IDLE;
            end else begin
              state <= (pend || xlate.req) ? T_RETRY : T_IDLE;
            end
          end
        end
        default: begin
          bus.req <= 1'b1;
          pend    <= 1'b0;
          state   <= T_WALK;
        end
      endcase
      if (flush) begin
        valid <= '0;
        pend  <= 1'b0;
        if ((state == T_WALK) && !bus.ack) discard <= 1'b1;
        if (state != T_WALK) begin
          bus.req <= 1'b0;
          state   <= T_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xlate.req) begin
      vpn_r <= xlate.vaddr.page.vpn;
      off_r <= xlate.vaddr.page.offset;
    end
    if (((state == T_IDLE) && xlate.req && !hit) || (state == T_RETRY)) begin
      bus.addr <= ptbr + ADDR_W'({walk_vpn, 3'b000});  // PTE is eight bytes
    end
    if ((state == T_IDLE) && xlate.req && hit) begin
      xlate.paddr <= {ppn_mem[idx], xlate.vaddr.page.offset};
    end
    if ((state == T_WALK) && bus.ack) begin
      tag_mem[fill_idx] <= vpn_r[VPN_W-1:IDX_W];
      ppn_mem[fill_idx] <= bus.rdata[ADDR_W-1:`MM_PAGE_BITS];
      xlate.paddr       <= {bus.rdata[ADDR_W-1:`MM_PAGE_BITS], off_r};
    end
  end

endmodule

`default_nettype wire

// File: rtl/mm_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_dcache (
  input  logic         clk,
  input  logic         reset,
  input  logic         flush,
  cache_if.slave       cache,
  mem_bus_if.requester bus
);

  localparam int IDX_W = $clog2(`MM_CACHE_LINES);
  localparam int OFF_W = $clog2(`MM_DATA_W / 8);
  localparam int TAG_W = `MM_ADDR_W - IDX_W - OFF_W;

  logic                       pending;  // Fill or write-through open on the bus
  logic                       discard;
  logic [`MM_CACHE_LINES-1:0] valid;
  logic [TAG_W-1:0]           tag_mem  [`MM_CACHE_LINES];
  logic [`MM_DATA_W-1:0]      data_mem [`MM_CACHE_LINES];
  logic [IDX_W-1:0]           idx;
  logic [IDX_W-1:0]           fill_idx;
  logic [TAG_W-1:0]           tag;
  logic                       hit;

  assign idx      = cache.addr[OFF_W +: IDX_W];
  assign tag      = cache.addr[`MM_ADDR_W-1 -: TAG_W];
  assign fill_idx = bus.addr[OFF_W +: IDX_W];
  assign hit      = valid[idx] && (tag_mem[idx] == tag);

  always_ff @(posedge clk) begin
    if (reset) begin
      pending    <= 1'b0;
      discard    <= 1'b0;
      valid      <= '0;
      cache.done <= 1'b0;
      bus.req    <= 1'b0;
    end else begin
      cache.done <= 1'b0;
      if (!pending) begin
        if (cache.req && !cache.we && hit) begin
          cache.done <= 1'b1;
        end else if (cache.req) begin
          bus.req <= 1'b1;
          pending <= 1'b1;
        end
      end else if (bus.ack) begin
        bus.req <= 1'b0;
        pending <= 1'b0;
        discard <= 1'b0;
        if (!discard && !flush) begin
          cache.done <= 1'b1;
          if (!bus.we) valid[fill_idx] <= 1'b1;  // No allocate on write
        end
      end
      if (flush) begin
        valid <= '0;
        if (pending && !bus.ack) discard <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!pending && cache.req) begin
      bus.we    <= cache.we;
      bus.addr  <= cache.addr;
      bus.wdata <= cache.wdata;
      if (cache.we && hit) data_mem[idx] <= cache.wdata;
      if (!cache.we) cache.rdata <= data_mem[idx];
    end
    if (pending && bus.ack && !bus.we) begin
      data_mem[fill_idx] <= bus.rdata;
      tag_mem[fill_idx]  <= bus.addr[`MM_ADDR_W-1 -: TAG_W];
      cache.rdata        <= bus.rdata;
    end
  end

endmodule

`default_nettype wire

// File: rtl/mm_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_bus_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  mem_bus_if.arbiter            tlb_bus,
  mem_bus_if.arbiter            cache_bus,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [`MM_ADDR_W-1:0] mem_addr,
  output logic [`MM_DATA_W-1:0] mem_wdata,
  input  logic                  mem_ack,
  input  logic [`MM_DATA_W-1:0] mem_rdata
);

  logic locked;     // Grant held from here until ack
  logic own_cache;

  always_ff @(posedge clk) begin
    if (reset) begin
      locked    <= 1'b0;
      own_cache <= 1'b0;
    end else if (!locked) begin
      if (tlb_bus.req) begin  // TLB walk wins
        locked    <= 1'b1;
        own_cache <= 1'b0;
      end else if (cache_bus.req) begin
        locked    <= 1'b1;
        own_cache <= 1'b1;
      end
    end else if (mem_ack) begin
      locked <= 1'b0;
    end
  end

  assign mem_req   = locked && (own_cache ? cache_bus.req : tlb_bus.req);
  assign mem_we    = own_cache ? cache_bus.we    : tlb_bus.we;
  assign mem_addr  = own_cache ? cache_bus.addr  : tlb_bus.addr;
  assign mem_wdata = own_cache ? cache_bus.wdata : tlb_bus.wdata;

  assign tlb_bus.ack     = locked && !own_cache && mem_ack;
  assign cache_bus.ack   = locked && own_cache && mem_ack;
  assign tlb_bus.rdata   = own_cache ? '0 : mem_rdata;
  assign cache_bus.rdata = own_cache ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: rtl/mm_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [`MM_OP_W-1:0]   op,
  input  logic [`MM_ADDR_W-1:0] vaddr,
  input  logic [`MM_DATA_W-1:0] store_data,
  input  logic [`MM_ADDR_W-1:0] ptbr,
  input  logic                  flush,
  output logic                  busy,
  output logic                  done,
  output logic [`MM_DATA_W-1:0] load_data,
  output logic [`MM_ADDR_W-1:0] paddr,
  output logic                  mem_req,
  output logic                  mem_we,
  output logic [`MM_ADDR_W-1:0] mem_addr,
  output logic [`MM_DATA_W-1:0] mem_wdata,
  input  logic                  mem_ack,
  input  logic [`MM_DATA_W-1:0] mem_rdata
);

  xlate_if   xlate ();
  cache_if   cache ();
  mem_bus_if tlb_bus ();
  mem_bus_if cache_bus ();

  mm_access_ctrl i_ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .op         (op),
    .vaddr      (vaddr),
    .store_data (store_data),
    .flush      (flush),
    .busy       (busy),
    .done       (done),
    .load_data  (load_data),
    .paddr      (paddr),
    .xlate      (xlate),
    .cache      (cache)
  );

  mm_tlb i_tlb (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .ptbr  (ptbr),
    .xlate (xlate),
    .bus   (tlb_bus)
  );

  mm_dcache i_dcache (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .cache (cache),
    .bus   (cache_bus)
  );

  mm_bus_arbiter i_arb (
    .clk       (clk),
    .reset     (reset),
    .tlb_bus   (tlb_bus),
    .cache_bus (cache_bus),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: sim/mm_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_stage_sva (
  input logic                  clk,
  input logic                  reset,
  input logic                  busy,
  input logic                  done,
  input logic                  mem_req,
  input logic                  mem_we,
  input logic [`MM_ADDR_W-1:0] mem_addr,
  input logic [`MM_DATA_W-1:0] mem_wdata,
  input logic                  mem_ack
);

  int fail_count = 0;  // Read by the testbench at the end of the run

  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
  else begin
    fail_count++;
    $error("mem_req dropped or its fields changed before mem_ack");
  end

  a_done_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
  else begin
    fail_count++;
    $error("done pulsed while busy was low in the previous cycle");
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
  else begin
    fail_count++;
    $error("done held high for more than one cycle");
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (reset) mem_ack |=> !mem_ack)
  else begin
    fail_count++;
    $error("mem_ack held high for more than one cycle");
  end

  a_reset_idle: assert property (@(posedge clk) reset |=> !busy)
  else begin
    fail_count++;
    $error("busy high after reset");
  end

endmodule

bind mm_stage mm_stage_sva i_sva (
  .clk       (clk),
  .reset     (reset),
  .busy      (busy),
  .done      (done),
  .mem_req   (mem_req),
  .mem_we    (mem_we),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_ack   (mem_ack)
);

`default_nettype wire

// File: sim/mm_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_stage_tb;

  logic                  clk;
  logic                  reset;
  logic                  start;
  logic [`MM_OP_W-1:0]   op;
  logic [`MM_ADDR_W-1:0] vaddr;
  logic [`MM_DATA_W-1:0] store_data;
  logic [`MM_ADDR_W-1:0] ptbr;
  logic                  flush;
  logic                  busy;
  logic                  done;
  logic [`MM_DATA_W-1:0] load_data;
  logic [`MM_ADDR_W-1:0] paddr;
  logic                  mem_req;
  logic                  mem_we;
  logic [`MM_ADDR_W-1:0] mem_addr;
  logic [`MM_DATA_W-1:0] mem_wdata;
  logic                  mem_ack;
  logic [`MM_DATA_W-1:0] mem_rdata;

  integer seed = 32'hbffc3780;
  integer delay_seed = 32'hbffc3780;  // Own stream for the bus delays
  int     errors = 0;
  int     ops_issued = 0;
  int     cycles = 0;

  logic [`MM_DATA_W-1:0] mem [logic [28:0]];     // Memory model, doubleword keyed
  logic [`MM_DATA_W-1:0] shadow [logic [28:0]];  // Expected memory contents
  logic [19:0]           ppn_tab [4];
  logic [`MM_DATA_W-1:0] exp_data_q [$];
  logic [`MM_ADDR_W-1:0] exp_addr_q [$];
  string                 name_q [$];
  string                 tname;
  logic                  serving;
  logic [1:0]            wait_cnt;
  logic [31:0]           rnd_delay;
  logic [3:0]            load_ops [7] = '{`MM_OP_LB, `MM_OP_LBU, `MM_OP_LH, `MM_OP_LHU,
                                          `MM_OP_LW, `MM_OP_LWU, `MM_OP_LD};

  mm_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [`MM_DATA_W-1:0] fill_word(input logic [28:0] dw);
    return {dw, 3'b011, ~dw, 3'b110};  // Unique per doubleword address
  endfunction

  function automatic logic [`MM_DATA_W-1:0] mem_word(input logic [`MM_ADDR_W-1:0] pa);
    return mem.exists(pa[31:3]) ? mem[pa[31:3]] : fill_word(pa[31:3]);
  endfunction

  function automatic logic [`MM_DATA_W-1:0] shadow_word(input logic [`MM_ADDR_W-1:0] pa);
    return shadow.exists(pa[31:3]) ? shadow[pa[31:3]] : fill_word(pa[31:3]);
  endfunction

  function automatic logic [`MM_ADDR_W-1:0] phys(input mm_pkg::mm_vaddr_u va);
    return {ppn_tab[va.page.vpn[1:0]], va.page.offset};
  endfunction

  // Expected load result from the addressed lanes of the memory word
  function automatic logic [`MM_DATA_W-1:0] ref_load(input logic [`MM_DATA_W-1:0] w,
                                                     input logic [3:0] code,
                                                     input logic [2:0] lane);
    logic [`MM_DATA_W-1:0] s;
    s = w >> (8 * lane);
    case (code)
      `MM_OP_LB:  return {{56{s[7]}}, s[7:0]};
      `MM_OP_LBU: return {56'd0, s[7:0]};
      `MM_OP_LH:  return {{48{s[15]}}, s[15:0]};
      `MM_OP_LHU: return {48'd0, s[15:0]};
      `MM_OP_LW:  return {{32{s[31]}}, s[31:0]};
      `MM_OP_LWU: return {32'd0, s[31:0]};
      default:    return s;
    endcase
  endfunction

  function automatic logic [`MM_DATA_W-1:0] merge_store(input logic [`MM_DATA_W-1:0] old,
                                                        input logic [3:0] code,
                                                        input logic [2:0] lane,
                                                        input logic [`MM_DATA_W-1:0] data);
    logic [`MM_DATA_W-1:0] w;
    int nbytes;
    w = old;
    nbytes = 1 << code[1:0];
    for (int i = 0; i < nbytes; i++) begin
      w[(lane + i) * 8 +: 8] = data[i * 8 +: 8];
    end
    return w;
  endfunction

  function automatic mm_pkg::mm_vaddr_u rand_addr(input logic [1:0] page, input logic [3:0] code);
    mm_pkg::mm_vaddr_u va;
    logic [31:0] rnd;
    rnd = $random(seed);
    va.page.vpn = page;
    va.page.offset = rnd[11:0];
    va.word.lane = va.word.lane & ~((3'd1 << code[1:0]) - 3'd1);  // Natural alignment
    return va;
  endfunction

  task automatic check_data(input string name, input logic [`MM_DATA_W-1:0] exp,
                            input logic [`MM_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [`MM_ADDR_W-1:0] exp,
                            input logic [`MM_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s paddr: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Issues one operation and returns 2 ns after the edge that raised done
  task automatic run_op(input string name, input logic [3:0] code,
                        input mm_pkg::mm_vaddr_u va, input logic [`MM_DATA_W-1:0] sdata);
    logic [`MM_ADDR_W-1:0] pa;
    pa = phys(va);
    if (code[3]) begin
      shadow[pa[31:3]] = merge_store(shadow_word(pa), code, va.word.lane, sdata);
      exp_data_q.push_back('0);
    end else begin
      exp_data_q.push_back(ref_load(shadow_word(pa), code, va.word.lane));
    end
    exp_addr_q.push_back(pa);
    name_q.push_back(name);
    ops_issued++;
    start = 1'b1;
    op = code;
    vaddr = va;
    store_data = sdata;
    @(posedge clk);
    #2;
    start = 1'b0;
    if (!busy) begin
      $display("ERROR: busy did not rise in the cycle after start of %s", name);
      errors++;
    end
    do begin
      @(posedge clk);
      #2;
    end while (!done);
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
  endtask

  task automatic finish_run();
    int total;
    total = errors + i_dut.i_sva.fail_count;
    $display("Errors: %0d (checks %0d, assertions %0d)", total, errors,
             i_dut.i_sva.fail_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // Memory model: ack after 1 to 4 cycles
  initial begin
    mem_ack = 1'b0;
    mem_rdata = '0;
    serving = 1'b0;
    wait_cnt = '0;
    forever begin
      @(posedge clk);
      #2;
      mem_ack = 1'b0;
      if (mem_req && !serving) begin
        serving = 1'b1;
        rnd_delay = $random(delay_seed);
        wait_cnt = rnd_delay[1:0];
      end
      if (serving) begin
        if (wait_cnt == 2'd0) begin
          serving = 1'b0;
          mem_ack = 1'b1;
          if (mem_we) mem[mem_addr[31:3]] = mem_wdata;
          else mem_rdata = mem_word(mem_addr);
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end
    end
  end

  // Compare process, samples in the middle of the done cycle
  always @(negedge clk) begin
    if (done) begin
      if (busy) begin
        $display("ERROR: busy still high in the cycle done pulsed");
        errors++;
      end
      if (name_q.size() == 0) begin
        $display("ERROR: done pulsed with no operation outstanding");
        errors++;
      end else begin
        tname = name_q.pop_front();
        check_data(tname, exp_data_q.pop_front(), load_data);
        check_addr(tname, exp_addr_q.pop_front(), paddr);
      end
    end
  end

  initial begin
    while (cycles < 40 * (ops_issued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: timeout after %0d cycles with %0d operations issued", cycles, ops_issued);
    errors++;
    finish_run();
  end

  initial begin
    mm_pkg::mm_vaddr_u va;
    logic [`MM_ADDR_W-1:0] pa;
    logic [`MM_DATA_W-1:0] sdata;
    reset = 1'b1;
    start = 1'b0;
    op = '0;
    vaddr = '0;
    store_data = '0;
    flush = 1'b0;
    ptbr = 32'h0001_0000;
    ppn_tab = '{20'h3a5c1, 20'h0f2e7, 20'h71b04, 20'h5d9a8};
    for (int p = 0; p < 4; p++) begin
      mem[ptbr[31:3] + p] = {32'd0, ppn_tab[p], 12'd0};  // Page table entries
    end
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;

    // All load types in each page, first walks then hits
    for (int p = 0; p < 4; p++) begin
      for (int k = 0; k < 7; k++) begin
        run_op($sformatf("load op%0h page%0d", load_ops[k], p), load_ops[k],
               rand_addr(p, load_ops[k]), '0);
      end
    end

    // Sub-word stores at every lane, each read back as a doubleword
    for (int sz = 0; sz < 3; sz++) begin
      for (int ln = 0; ln < 8; ln += (1 << sz)) begin
        va.page.vpn = 20'd1;
        va.page.offset = 12'h100 + 12'h40 * sz;
        va.word.lane = ln;
        pa = phys(va);
        sdata = {$random(seed), $random(seed)};
        run_op($sformatf("store size%0d lane%0d", sz, ln), {2'b10, sz[1:0]}, va, sdata);
        check_data($sformatf("memory size%0d lane%0d", sz, ln), shadow_word(pa), mem_word(pa));
        va.word.lane = 3'd0;
        run_op($sformatf("readback size%0d lane%0d", sz, ln), `MM_OP_LD, va, '0);
      end
    end

    // Doubleword store then load
    for (int p = 2; p < 4; p++) begin
      va = rand_addr(p, `MM_OP_SD);
      sdata = {$random(seed), $random(seed)};
      run_op($sformatf("sd page%0d", p), `MM_OP_SD, va, sdata);
      run_op($sformatf("ld after sd page%0d", p), `MM_OP_LD, va, '0);
    end

    // Memory changed behind the cache, visible only after a flush
    va.page.vpn = 20'd0;
    va.page.offset = 12'h2a8;
    pa = phys(va);
    run_op("stale fill", `MM_OP_LD, va, '0);
    mem[pa[31:3]] = ~shadow_word(pa);
    run_op("stale hit", `MM_OP_LD, va, '0);
    pulse_flush();
    shadow[pa[31:3]] = mem[pa[31:3]];
    run_op("after flush", `MM_OP_LD, va, '0);

    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/mm_pkg.sv
rtl/mm_ifs.sv
rtl/mm_lane_unit.sv
rtl/mm_access_ctrl.sv
rtl/mm_tlb.sv
rtl/mm_dcache.sv
rtl/mm_bus_arbiter.sv
rtl/mm_stage.sv
sim/mm_stage_sva.sv
sim/mm_stage_tb.sv

// File: Bender.yml
package:
  name: mm_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mm_pkg.sv
      - rtl/mm_ifs.sv
      - rtl/mm_lane_unit.sv
      - rtl/mm_access_ctrl.sv
      - rtl/mm_tlb.sv
      - rtl/mm_dcache.sv
      - rtl/mm_bus_arbiter.sv
      - rtl/mm_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/mm_stage_sva.sv
      - sim/mm_stage_tb.sv
